// File: Makefile
# Verilator build and run of the cart mapper testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_mapper
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_cart_mapper.sv
// concurrent assertions need verilator --assert, the clocked stimulus needs --timing
module tb_cart_mapper;

   logic                  clk64;
   logic                  reset;
   cart_pkg::dl_write_t   dl;
   cart_pkg::cart_bus_t   cart;
   cart_pkg::mem_word_t   mem_rdata;
   cart_pkg::mem_req_t    mem_req;
   cart_pkg::cart_byte_t  cart_rdata;
   logic                  cgb_game;

   cart_pkg::cart_info_t  mi;         // header as the model decodes it
   cart_pkg::mbc_state_t  ms;         // model bank registers
   cart_pkg::mem_req_t    exp_req;    // request due one cycle after the drive
   cart_pkg::cart_byte_t  exp_byte;   // byte due on cart_rdata for a read
   cart_pkg::cart_info_t  exp_info;
   int                    errors;
   int                    timeouts;
   integer                seed;

   cart_mapper_top cart_mapper_top_i (
      .clk64      (clk64),
      .reset      (reset),
      .dl         (dl),
      .cart       (cart),
      .mem_rdata  (mem_rdata),
      .mem_req    (mem_req),
      .cart_rdata (cart_rdata),
      .cgb_game   (cgb_game)
   );

   initial begin
      clk64 = 1'b0;
      forever #5 clk64 = ~clk64;
   end

   function automatic void flag_error(input string msg);
      errors++;
      $display("error %0t: %s", $time, msg);
   endfunction

   // --------------------------------------------------
   // reference rules
   // --------------------------------------------------
   function automatic cart_pkg::mbc_kind_e kind_for(input cart_pkg::cart_byte_t t);
      if (t >= 8'd1 && t <= 8'd3) return cart_pkg::kind_mbc1;
      if (t == 8'd5 || t == 8'd6) return cart_pkg::kind_mbc2;
      if (t >= 8'd15 && t <= 8'd19) return cart_pkg::kind_mbc3;
      if (t >= 8'd25 && t <= 8'd30) return cart_pkg::kind_mbc5;
      return cart_pkg::kind_none;   // unknown types act as plain rom
   endfunction

   function automatic cart_pkg::rom_bank_t rom_mask_for(input cart_pkg::cart_byte_t c);
      int banks;
      banks = 2 << c;   // 2^(n+1) banks
      if (c >= 8'd1 && c <= 8'd8)
         return cart_pkg::rom_bank_t'(banks - 1);
      return 9'h07f;
   endfunction

   function automatic cart_pkg::ram_bank_t ram_mask_for(input cart_pkg::cart_byte_t c);
      if (c == 8'd1 || c == 8'd2) return 4'b0000;
      if (c == 8'd3) return 4'b0011;
      return 4'b1111;
   endfunction

   function automatic logic in_ram_window(input cart_pkg::cart_addr_t a);
      if (mi.kind == cart_pkg::kind_mbc2)
         return a >= 16'ha000 && a < 16'ha200;   // 512 nibbles only
      return a >= 16'ha000 && a < 16'hc000;
   endfunction

   function automatic cart_pkg::bank_sel_t bank_for(input cart_pkg::cart_addr_t a);
      cart_pkg::rom_bank_t rom;
      cart_pkg::ram_bank_t ram;
      rom = '0;
      ram = '0;
      case (mi.kind)
         cart_pkg::kind_mbc1: begin   // ram reg is rom bits 6:5 in mode 0
            rom = {2'b00, ms.mbc1_mode ? 2'b00 : ms.ram_bank[1:0], ms.rom_bank[4:0]};
            rom = rom & mi.rom_mask & 9'h07f;
            ram = ms.mbc1_mode ? (ms.ram_bank & mi.ram_mask & 4'h3) : 4'h0;
         end
         cart_pkg::kind_mbc2: rom = ms.rom_bank & mi.rom_mask & 9'h00f;
         cart_pkg::kind_mbc3: begin
            rom = ms.rom_bank & mi.rom_mask & 9'h07f;
            ram = ms.ram_bank & mi.ram_mask & 4'h3;
         end
         cart_pkg::kind_mbc5: begin
            rom = ms.rom_bank & mi.rom_mask;
            ram = ms.ram_bank & mi.ram_mask;
         end
         default: ;
      endcase
      if (mi.kind == cart_pkg::kind_none) return {9'd0, a[14:13]};
      if (a < 16'h4000) return {10'd0, a[13]};
      if (a < 16'h8000) return {1'b0, rom, a[13]};
      if (in_ram_window(a)) return {7'b1000000, ram};
      return '0;
   endfunction

   function automatic void update_regs(input cart_pkg::cart_addr_t a,
                                       input cart_pkg::cart_byte_t d);
      case (a[15:13])
         cart_pkg::REGION_RAM_ENABLE: ms.ram_enable = (d[3:0] == cart_pkg::RAM_ENABLE_KEY);
         cart_pkg::REGION_ROM_BANK:
            if (mi.kind == cart_pkg::kind_mbc5 && a[13:12] == 2'b11) ms.rom_bank[8] = d[0];
            else if (mi.kind == cart_pkg::kind_mbc5) ms.rom_bank[7:0] = d;
            else ms.rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
         cart_pkg::REGION_RAM_BANK:
            if (mi.kind == cart_pkg::kind_mbc3 && d[3]) ms.rtc_select = 1'b1;
            else if (mi.kind == cart_pkg::kind_mbc3) begin
               ms.rtc_select = 1'b0;
               ms.ram_bank   = {2'b00, d[1:0]};
            end else if (mi.kind == cart_pkg::kind_mbc5) ms.ram_bank = d[3:0];
            else ms.ram_bank = {2'b00, d[1:0]};
         cart_pkg::REGION_MODE: ms.mbc1_mode = d[0];
         default: ;
      endcase
   endfunction

   // --------------------------------------------------
   // stimulus, one drive per rising edge
   // --------------------------------------------------
   task automatic idle_cycle;
      @(posedge clk64);
      dl      <= '0;
      cart    <= '0;
      exp_req <= '0;
   endtask

   // download cycle, with a cart read and write that must be ignored
   task automatic dl_write(input cart_pkg::mem_addr_t addr, input cart_pkg::mem_word_t data,
                           input logic wr);   // wr low keeps dl.active without the strobe
      @(posedge clk64);
      dl      <= '{active: 1'b1, write: wr, addr: addr, data: data};
      cart    <= '{addr: 16'($random(seed)), rd: 1'b1, wr: 1'b1, wdata: 8'($random(seed))};
      exp_req <= '{addr: addr, wdata: data, ds: 2'b11, we: wr, oe: 1'b0};
      if (wr) begin
         if (addr == cart_pkg::HDR_CGB_WORD)
            mi.cgb_game = (data[7:0] == cart_pkg::CGB_ONLY) ||
                          (data[7:0] == cart_pkg::CGB_DUAL);
         if (addr == cart_pkg::HDR_TYPE_WORD) mi.kind = kind_for(data[7:0]);
         if (addr == cart_pkg::HDR_SIZE_WORD) begin   // rom code high, ram code low
            mi.rom_mask = rom_mask_for(data[15:8]);
            mi.ram_mask = ram_mask_for(data[7:0]);
         end
      end
      exp_info <= mi;
   endtask

   task automatic cart_access(input cart_pkg::cart_addr_t a, input logic rd, input logic wr,
                              input cart_pkg::cart_byte_t d);
      logic ram_wr;
      ram_wr = wr && ms.ram_enable && in_ram_window(a);
      @(posedge clk64);
      dl       <= '0;
      cart     <= '{addr: a, rd: rd, wr: wr, wdata: d};
      exp_req  <= '{addr: {1'b0, bank_for(a), a[12:1]}, wdata: {d, d},
                    ds: {~a[0], a[0]}, we: ram_wr, oe: rd};
      exp_byte <= a[0] ? mem_rdata[7:0] : mem_rdata[15:8];   // even byte is the upper one
      if (wr) update_regs(a, d);
   endtask

   task automatic window_access(input cart_pkg::cart_addr_t base, input cart_pkg::cart_addr_t span,
                                input logic rd, input logic wr, input int n);
      cart_pkg::cart_addr_t a;
      repeat (n) begin
         a = base | (16'($random(seed)) & span);
         cart_access(a, rd, wr, 8'($random(seed)));
      end
   endtask

   task automatic load_header(input cart_pkg::cart_byte_t cgb, input cart_pkg::cart_byte_t typ,
                              input cart_pkg::cart_byte_t rom, input cart_pkg::cart_byte_t ram);
      dl_write(cart_pkg::HDR_CGB_WORD, {8'h00, cgb}, 1'b1);
      dl_write(cart_pkg::HDR_TYPE_WORD, {8'h00, typ}, 1'b1);
      dl_write(cart_pkg::HDR_SIZE_WORD, {rom, ram}, 1'b1);
   endtask

   // let the pipe empty, bounded
   task automatic wait_idle(input int limit);
      int n;
      n = 0;
      do begin
         idle_cycle();
         @(negedge clk64);
         n++;
      end while ((mem_req.we || mem_req.oe) && n < limit);
      if (mem_req.we || mem_req.oe) begin
         timeouts++;
         $display("timeout at %0t: memory request still active after %0d cycles", $time, limit);
      end
   endtask

   // --------------------------------------------------
   // checks, sampled one cycle after the drive
   // --------------------------------------------------
   a_strobes: assert property (@(posedge clk64) disable iff (reset)
      mem_req.we == $past(exp_req.we) && mem_req.oe == $past(exp_req.oe))
      else flag_error($sformatf("we %b oe %b not as predicted", mem_req.we, mem_req.oe));
   a_addr: assert property (@(posedge clk64) disable iff (reset)
      $past(exp_req.we || exp_req.oe) |->
         mem_req.addr == $past(exp_req.addr) && mem_req.ds == $past(exp_req.ds))
      else flag_error($sformatf("addr %h ds %b not as predicted", mem_req.addr, mem_req.ds));
   a_wdata: assert property (@(posedge clk64) disable iff (reset)
      $past(exp_req.we) |-> mem_req.wdata == $past(exp_req.wdata))
      else flag_error($sformatf("write data %h not as predicted", mem_req.wdata));
   a_dl_no_read: assert property (@(posedge clk64) disable iff (reset)
      $past(dl.active) |-> !mem_req.oe)
      else flag_error("cart read passed during download");
   a_info: assert property (@(posedge clk64) disable iff (reset)
      cart_mapper_top_i.info == $past(exp_info))
      else flag_error($sformatf("cart info %h not as decoded", cart_mapper_top_i.info));
   a_cgb: assert property (@(posedge clk64) disable iff (reset)
      cgb_game == $past(exp_info.cgb_game))
      else flag_error("cgb_game port wrong");
   a_rdata: assert property (@(posedge clk64) disable iff (reset)
      $past(exp_req.oe) |-> cart_rdata == $past(exp_byte))
      else flag_error($sformatf("cart_rdata %h is the wrong byte", cart_rdata));

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      seed     = 32'h6a0b_179e;
      errors   = 0;
      timeouts = 0;
      mi       = '0;
      ms       = '0;
      ms.rom_bank = 9'd1;   // reset value of the rom bank
      exp_req  <= '0;
      exp_byte <= '0;
      exp_info <= '0;
      reset     <= 1'b1;
      dl        <= '0;
      cart      <= '0;
      mem_rdata <= 16'hb74e;   // known word for all reads
      repeat (3) @(posedge clk64);
      reset <= 1'b0;

      repeat (16) dl_write(24'($random(seed)), 16'($random(seed)), 1'b1);   // passthrough
      wait_idle(8);

      load_header(8'h80, 8'h02, 8'h52, 8'h03);   // rom 82 and ram 3
      load_header(8'hc0, 8'h06, 8'h05, 8'h01);
      load_header(8'h00, 8'h13, 8'h08, 8'h02);
      load_header(8'h40, 8'h1b, 8'h00, 8'h04);
      load_header(8'h80, 8'h04, 8'h09, 8'h05);   // unknown type
      load_header(8'hc0, 8'h20, 8'h01, 8'h00);
      dl_write(cart_pkg::HDR_CGB_WORD, 16'h0000, 1'b0);    // active without write strobe
      dl_write(cart_pkg::HDR_TYPE_WORD, 16'h0001, 1'b0);
      dl_write(cart_pkg::HDR_SIZE_WORD, 16'h0803, 1'b0);
      window_access(16'h0000, 16'h7fff, 1'b1, 1'b0, 8);   // no mapper
      wait_idle(8);

      load_header(8'h00, 8'h01, 8'h06, 8'h03);   // mbc1, 128 banks
      cart_access(16'h2000, 1'b0, 1'b1, 8'h00);   // bank 0 reads as 1
      window_access(16'h4000, 16'h3fff, 1'b1, 1'b0, 4);
      window_access(16'h0000, 16'h7fff, 1'b1, 1'b0, 8);
      cart_access(16'h2100, 1'b0, 1'b1, 8'($random(seed)));
      cart_access(16'h4000, 1'b0, 1'b1, 8'h02);
      window_access(16'h0000, 16'h7fff, 1'b1, 1'b0, 12);   // mode 0
      cart_access(16'h6000, 1'b0, 1'b1, 8'h01);
      window_access(16'h0000, 16'h7fff, 1'b1, 1'b0, 12);   // mode 1
      window_access(16'ha000, 16'h1fff, 1'b1, 1'b0, 4);
      wait_idle(8);

      load_header(8'h80, 8'h19, 8'h08, 8'h04);   // mbc5, 512 banks
      cart_access(16'h2000, 1'b0, 1'b1, 8'($random(seed)));
      cart_access(16'h3000, 1'b0, 1'b1, 8'h01);   // bank bit 8
      window_access(16'h4000, 16'h3fff, 1'b1, 1'b0, 6);
      cart_access(16'h3000, 1'b0, 1'b1, 8'h00);
      cart_access(16'h4000, 1'b0, 1'b1, 8'($random(seed)));
      window_access(16'h4000, 16'h3fff, 1'b1, 1'b0, 4);
      window_access(16'ha000, 16'h1fff, 1'b1, 1'b0, 4);
      load_header(8'h00, 8'h05, 8'h03, 8'h00);   // mbc2
      cart_access(16'h2000, 1'b0, 1'b1, 8'($random(seed)));
      window_access(16'h0000, 16'h7fff, 1'b1, 1'b0, 6);
      window_access(16'ha000, 16'h01ff, 1'b1, 1'b0, 4);
      window_access(16'ha000, 16'h1fff, 1'b1, 1'b0, 6);
      wait_idle(8);

      load_header(8'h00, 8'h11, 8'h05, 8'h03);   // mbc3
      cart_access(16'h4000, 1'b0, 1'b1, 8'h03);   // ram bank 3 before the clock select
      cart_access(16'h4000, 1'b0, 1'b1, 8'h08);   // clock select on
      window_access(16'ha000, 16'h1fff, 1'b0, 1'b1, 3);   // ram still closed
      cart_access(16'h0000, 1'b0, 1'b1, 8'h3a);
      window_access(16'ha000, 16'h1fff, 1'b0, 1'b1, 4);
      cart_access(16'h4000, 1'b0, 1'b1, 8'h02);   // clock off, bank 2
      window_access(16'ha000, 16'h1fff, 1'b0, 1'b1, 4);
      window_access(16'hc000, 16'h3fff, 1'b0, 1'b1, 3);   // outside the window
      cart_access(16'h0000, 1'b0, 1'b1, 8'h00);
      window_access(16'ha000, 16'h1fff, 1'b0, 1'b1, 3);
      wait_idle(8);

      @(posedge clk64);
      mem_rdata <= 16'($random(seed));   // pipe is empty, safe to swap the word
      window_access(16'h0000, 16'h7ffe, 1'b1, 1'b0, 4);   // even bytes
      window_access(16'h0001, 16'h7ffe, 1'b1, 1'b0, 4);   // odd bytes
      wait_idle(8);

      $display("checks done: %0d assertion errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: list.f
source/cart_pkg.sv
source/cart_header_capture.sv
source/mbc_regs.sv
source/bank_mapper.sv
source/mem_request.sv
source/cart_mapper_top.sv
dv/tb_cart_mapper.sv

// File: source/bank_mapper.sv
// purely combinational; bank select assumes the 24-bit word map with rom low and cart ram above bit 22
module bank_mapper (
   input  cart_pkg::cart_bus_t       cart,
   input  cart_pkg::cart_info_t      info,
   input  cart_pkg::mbc_state_t      state,
   output cart_pkg::mapped_access_t  access
);

   // memory map of the bank select, word address bits 22:12
   //   rom : 0 b b b b b b b b b c   (c = cpu address bit 13)
   //   ram : 1 0 0 0 0 0 0 r r r r
   //   mbc2 ram has no bank bits

   // --------------------------------------------------
   // masked banks per mapper kind
   // --------------------------------------------------
   logic [6:0] mbc1_rom;
   logic [1:0] mbc1_ram;
   logic [3:0] mbc2_rom;
   logic [6:0] mbc3_rom;
   logic [1:0] mbc3_ram;

   // mode 0 feeds the ram register into rom bits 6:5, mode 1 uses it for ram
   assign mbc1_rom = {state.mbc1_mode ? 2'b00 : state.ram_bank[1:0],
                      state.rom_bank[4:0]} & info.rom_mask[6:0];
   assign mbc1_ram = (state.mbc1_mode ? state.ram_bank[1:0] : 2'b00) & info.ram_mask[1:0];
   assign mbc2_rom = state.rom_bank[3:0] & info.rom_mask[3:0];   // 16 banks
   assign mbc3_rom = state.rom_bank[6:0] & info.rom_mask[6:0];   // 128 banks
   assign mbc3_ram = state.ram_bank[1:0] & info.ram_mask[1:0];

   cart_pkg::rom_bank_t rom_sel;   // rom bank after masking, zero extended
   cart_pkg::ram_bank_t ram_sel;   // ram bank after masking, zero extended

   always_comb begin
      case (info.kind)
         cart_pkg::kind_mbc1: begin
            rom_sel = {2'b00, mbc1_rom};
            ram_sel = {2'b00, mbc1_ram};
         end
         cart_pkg::kind_mbc2: begin
            rom_sel = {5'd0, mbc2_rom};
            ram_sel = '0;   // single 512 byte block
         end
         cart_pkg::kind_mbc3: begin
            rom_sel = {2'b00, mbc3_rom};
            ram_sel = {2'b00, mbc3_ram};
         end
         cart_pkg::kind_mbc5: begin
            rom_sel = state.rom_bank & info.rom_mask;   // full 9 bits
            ram_sel = state.ram_bank & info.ram_mask;
         end
         default: begin   // no banking at all
            rom_sel = '0;
            ram_sel = '0;
         end
      endcase
   end

   // --------------------------------------------------
   // window decode and bank select
   // --------------------------------------------------
   logic ext_ram_hit;   // cpu address falls into cart ram

   assign ext_ram_hit = (info.kind == cart_pkg::kind_mbc2) ?
                        (cart.addr[15:9] == cart_pkg::MBC2_RAM_PREFIX) :
                        (cart.addr[15:13] == cart_pkg::REGION_EXT_RAM);

   always_comb begin
      if (info.kind == cart_pkg::kind_none)
         access.bank = {9'd0, cart.addr[14:13]};           // flat 32k rom
      else if (cart.addr[15:14] == 2'b00)
         access.bank = {10'd0, cart.addr[13]};             // fixed bank 0
      else if (cart.addr[15:14] == 2'b01)
         access.bank = {1'b0, rom_sel, cart.addr[13]};     // switchable rom
      else if (ext_ram_hit)
         access.bank = {1'b1, 6'd0, ram_sel};              // cart ram
      else
         access.bank = '0;   // vram, wram and io never reach the cart
   end

   // writes reach memory only into opened cart ram
   assign access.ram_wr = cart.wr & state.ram_enable & ext_ram_hit;

endmodule

// File: source/cart_header_capture.sv
// header bytes are only seen on download writes; a header rewritten later simply overwrites the info
module cart_header_capture (
   input  logic                  clk64,
   input  logic                  reset,
   input  cart_pkg::dl_write_t   dl,     // download write stream
   output cart_pkg::cart_info_t  info    // decoded cartridge info
);

   // --------------------------------------------------
   // decode helpers
   // --------------------------------------------------

   // cartridge type byte $147 to mapper kind
   function automatic cart_pkg::mbc_kind_e kind_of(input cart_pkg::cart_byte_t t);
      case (t) inside
         [8'd1:8'd3]:   return cart_pkg::kind_mbc1;   // mbc1, +ram, +ram+bat
         [8'd5:8'd6]:   return cart_pkg::kind_mbc2;
         [8'd15:8'd19]: return cart_pkg::kind_mbc3;   // timer variants included
         [8'd25:8'd30]: return cart_pkg::kind_mbc5;   // rumble variants included
         default:       return cart_pkg::kind_none;
      endcase
   endfunction

   // rom size code $148: code n means 2^(n+1) banks
   function automatic cart_pkg::rom_bank_t rom_mask_of(input cart_pkg::cart_byte_t code);
      logic [9:0] ones;
      ones = (10'd1 << (code[3:0] + 4'd1)) - 10'd1;   // n+1 low bits set
      if (code >= 8'd1 && code <= 8'd8)
         return ones[8:0];
      else
         return 9'h07f;   // 0 and odd sizes like $52..$54 use 128 banks
   endfunction

   // ram size code $149 to bank mask
   function automatic cart_pkg::ram_bank_t ram_mask_of(input cart_pkg::cart_byte_t code);
      case (code)
         8'd1, 8'd2: return 4'b0000;   // 2k or 8k, single bank
         8'd3:       return 4'b0011;   // 32k in 4 banks
         default:    return 4'b1111;   // 128k in 16 banks
      endcase
   endfunction

   // --------------------------------------------------
   // capture
   // --------------------------------------------------
   logic dl_strobe;   // a download write that counts

   assign dl_strobe = dl.active & dl.write;

   always_ff @(posedge clk64) begin
      if (reset) begin
         info.kind     <= cart_pkg::kind_none;
         info.rom_mask <= '0;
         info.ram_mask <= '0;
         info.cgb_game <= 1'b0;
      end else if (dl_strobe) begin
         case (dl.addr)
            cart_pkg::HDR_CGB_WORD:   // $143, colour flag
               info.cgb_game <= (dl.data[7:0] == cart_pkg::CGB_DUAL) ||
                                (dl.data[7:0] == cart_pkg::CGB_ONLY);
            cart_pkg::HDR_TYPE_WORD:
               info.kind <= kind_of(dl.data[7:0]);   // $147
            cart_pkg::HDR_SIZE_WORD: begin   // $148 sits in the high byte
               info.rom_mask <= rom_mask_of(dl.data[15:8]);
               info.ram_mask <= ram_mask_of(dl.data[7:0]);
            end
            default: ;   // rest of the image passes by
         endcase
      end
   end

endmodule

// File: source/cart_mapper_top.sv
// cart mapper top; memory must accept a request every clk64 cycle and answer within that cycle
module cart_mapper_top (
   input  logic                  clk64,
   input  logic                  reset,
   input  cart_pkg::dl_write_t   dl,          // rom download port
   input  cart_pkg::cart_bus_t   cart,        // cpu cartridge bus
   input  cart_pkg::mem_word_t   mem_rdata,
   output cart_pkg::mem_req_t    mem_req,
   output cart_pkg::cart_byte_t  cart_rdata,
   output logic                  cgb_game     // colour title found in header
);

   cart_pkg::cart_info_t     info;     // decoded header
   cart_pkg::mbc_state_t     state;    // bank registers
   cart_pkg::mapped_access_t access;   // bank select and write gate

   // --------------------------------------------------
   // stage 1, header capture
   // --------------------------------------------------
   cart_header_capture header_capture_i (
      .clk64 (clk64),
      .reset (reset),
      .dl    (dl),
      .info  (info)
   );

   // stage 2, bank registers
   mbc_regs mbc_regs_i (
      .clk64     (clk64),
      .reset     (reset),
      .dl_active (dl.active),
      .cart      (cart),
      .info      (info),
      .state     (state)
   );

   // stage 3, address mapping, no clock
   bank_mapper bank_mapper_i (
      .cart   (cart),
      .info   (info),
      .state  (state),
      .access (access)
   );

   // stage 4, registered memory request
   mem_request mem_request_i (
      .clk64      (clk64),
      .reset      (reset),
      .dl         (dl),
      .cart       (cart),
      .access     (access),
      .mem_rdata  (mem_rdata),
      .mem_req    (mem_req),
      .cart_rdata (cart_rdata)
   );

   assign cgb_game = info.cgb_game;

endmodule

// File: source/cart_pkg.sv
// shared types for the cart mapper; memory word addresses are 16-bit words and bus widths are fixed
package cart_pkg;

   // --------------------------------------------------
   // widths that carry a meaning
   // --------------------------------------------------
   typedef logic [15:0] cart_addr_t;   // cpu side cartridge address
   typedef logic [7:0]  cart_byte_t;   // cpu side data byte
   typedef logic [15:0] mem_word_t;    // external memory data word
   typedef logic [23:0] mem_addr_t;    // external memory word address
   typedef logic [8:0]  rom_bank_t;    // up to 512 rom banks (mbc5)
   typedef logic [3:0]  ram_bank_t;    // up to 16 ram banks (mbc5)
   typedef logic [10:0] bank_sel_t;    // sits above the 12-bit word offset

   // mapper kind decoded from header byte $147
   typedef enum logic [2:0] {
      kind_none = 3'd0,   // plain 32k rom, also every unknown type
      kind_mbc1 = 3'd1,
      kind_mbc2 = 3'd2,
      kind_mbc3 = 3'd3,
      kind_mbc5 = 3'd4
   } mbc_kind_e;

   // --------------------------------------------------
   // bundles passed between stages
   // --------------------------------------------------

   // rom download write from the loader side
   typedef struct packed {
      logic      active;   // download in progress, cart bus is ignored
      logic      write;    // one cycle strobe for addr/data
      mem_addr_t addr;
      mem_word_t data;
   } dl_write_t;

   // one cpu access on the cartridge bus
   typedef struct packed {
      cart_addr_t addr;
      logic       rd;      // single cycle read strobe
      logic       wr;      // single cycle write strobe
      cart_byte_t wdata;
   } cart_bus_t;

   // header fields after decoding
   typedef struct packed {
      mbc_kind_e kind;
      rom_bank_t rom_mask;   // mirrors rom banks above the image size
      ram_bank_t ram_mask;
      logic      cgb_game;   // colour or dual mode title
   } cart_info_t;

   // bank switching registers as the cpu sees them
   typedef struct packed {
      rom_bank_t rom_bank;
      ram_bank_t ram_bank;
      logic      ram_enable;
      logic      mbc1_mode;    // 0: 16/8 mode, 1: 4/32 mode
      logic      rtc_select;   // mbc3 clock register selected instead of ram
   } mbc_state_t;

   // result of the address mapping
   typedef struct packed {
      bank_sel_t bank;
      logic      ram_wr;   // write may reach cart ram
   } mapped_access_t;

   // request handed to the external memory each cycle
   typedef struct packed {
      mem_addr_t  addr;
      mem_word_t  wdata;
      logic [1:0] ds;   // byte lanes, upper first
      logic       we;
      logic       oe;
   } mem_req_t;

   // --------------------------------------------------
   // header locations, word addressed
   // --------------------------------------------------
   localparam mem_addr_t HDR_CGB_WORD  = 24'h0000a1;   // $143 in low byte
   localparam mem_addr_t HDR_TYPE_WORD = 24'h0000a3;   // $147 in low byte
   localparam mem_addr_t HDR_SIZE_WORD = 24'h0000a4;   // $148 high, $149 low

   localparam logic [3:0] RAM_ENABLE_KEY = 4'ha;   // low nibble that opens cart ram

   // region codes taken from address bits 15:13
   localparam logic [2:0] REGION_RAM_ENABLE = 3'd0;   // 0000-1fff
   localparam logic [2:0] REGION_ROM_BANK   = 3'd1;   // 2000-3fff
   localparam logic [2:0] REGION_RAM_BANK   = 3'd2;   // 4000-5fff
   localparam logic [2:0] REGION_MODE       = 3'd3;   // 6000-7fff
   localparam logic [2:0] REGION_EXT_RAM    = 3'd5;   // a000-bfff

   // mbc2 has only 512 nibbles of internal ram at a000-a1ff
   localparam logic [6:0] MBC2_RAM_PREFIX = 7'b1010000;

   // cgb flag values that mark a colour title
   localparam cart_byte_t CGB_ONLY = 8'hc0;
   localparam cart_byte_t CGB_DUAL = 8'h80;

endpackage

// File: source/mbc_regs.sv
// cpu writes are decoded by region only; the mbc3 clock itself is absent, only its select bit stays
module mbc_regs (
   input  logic                  clk64,
   input  logic                  reset,
   input  logic                  dl_active,   // cart bus ignored while loading
   input  cart_pkg::cart_bus_t   cart,
   input  cart_pkg::cart_info_t  info,
   output cart_pkg::mbc_state_t  state
);

   logic       reg_wr;    // qualified register write
   logic [2:0] region;    // address bits 15:13
   logic       is_mbc3;
   logic       is_mbc5;

   assign reg_wr  = cart.wr & ~dl_active;
   assign region  = cart.addr[15:13];
   assign is_mbc3 = (info.kind == cart_pkg::kind_mbc3);
   assign is_mbc5 = (info.kind == cart_pkg::kind_mbc5);

   // --------------------------------------------------
   // register file
   // --------------------------------------------------
   always_ff @(posedge clk64) begin
      if (reset) begin
         state.rom_bank   <= 9'd1;   // bank 1 in the switchable window
         state.ram_bank   <= '0;
         state.ram_enable <= 1'b0;
         state.mbc1_mode  <= 1'b0;
         state.rtc_select <= 1'b0;
      end else if (reg_wr) begin
         case (region)
            cart_pkg::REGION_RAM_ENABLE:
               // only the magic nibble opens ram, anything else closes it
               state.ram_enable <= (cart.wdata[3:0] == cart_pkg::RAM_ENABLE_KEY);

            cart_pkg::REGION_ROM_BANK: begin
               if (is_mbc5) begin
                  if (cart.addr[13:12] == 2'b11)
                     state.rom_bank[8] <= cart.wdata[0];       // 3000-3fff high bit
                  else
                     state.rom_bank[7:0] <= cart.wdata;        // 2000-2fff low byte
               end else if (cart.wdata[6:0] == 7'd0) begin
                  state.rom_bank <= 9'd1;   // bank 0 maps to 1 on mbc1-3
               end else begin
                  state.rom_bank <= {2'b00, cart.wdata[6:0]};
               end
            end

            cart_pkg::REGION_RAM_BANK: begin
               if (is_mbc3) begin
                  if (cart.wdata[3]) begin
                     state.rtc_select <= 1'b1;   // clock reg picked, ram bank kept
                  end else begin
                     state.rtc_select <= 1'b0;
                     state.ram_bank   <= {2'b00, cart.wdata[1:0]};
                  end
               end else if (is_mbc5) begin
                  state.ram_bank <= cart.wdata[3:0];   // 16 banks
               end else begin
                  state.ram_bank <= {2'b00, cart.wdata[1:0]};   // mbc1 upper bits too
               end
            end

            cart_pkg::REGION_MODE:
               state.mbc1_mode <= cart.wdata[0];   // banking mode select

            default: ;   // writes into rom or ram windows leave registers alone
         endcase
      end
   end

endmodule

// File: source/mem_request.sv
// one request per cycle with no back-pressure; read data must arrive while the request is still held
module mem_request (
   input  logic                      clk64,
   input  logic                      reset,
   input  cart_pkg::dl_write_t       dl,
   input  cart_pkg::cart_bus_t       cart,
   input  cart_pkg::mapped_access_t  access,
   input  cart_pkg::mem_word_t       mem_rdata,   // word for the registered request
   output cart_pkg::mem_req_t        mem_req,
   output cart_pkg::cart_byte_t      cart_rdata
);

   cart_pkg::mem_req_t req_next;   // request before the register
   logic               lane_odd;   // byte lane of the held request

   // --------------------------------------------------
   // request select, download wins over the cpu
   // --------------------------------------------------
   always_comb begin
      if (dl.active) begin
         req_next.addr  = dl.addr;
         req_next.wdata = dl.data;
         req_next.ds    = 2'b11;      // whole word
         req_next.we    = dl.write;
         req_next.oe    = 1'b0;       // cpu reads dropped while loading
      end else begin
         req_next.addr  = {1'b0, access.bank, cart.addr[12:1]};
         req_next.wdata = {cart.wdata, cart.wdata};   // byte on both lanes
         req_next.ds    = {~cart.addr[0], cart.addr[0]};   // even byte is upper
         req_next.we    = access.ram_wr;
         req_next.oe    = cart.rd;
      end
   end

   always_ff @(posedge clk64) begin
      mem_req.addr  <= req_next.addr;
      mem_req.wdata <= req_next.wdata;
      mem_req.ds    <= req_next.ds;
      lane_odd      <= cart.addr[0];
      if (reset) begin
         mem_req.we <= 1'b0;
         mem_req.oe <= 1'b0;
      end else begin
         mem_req.we <= req_next.we;
         mem_req.oe <= req_next.oe;
      end
   end

   // pick the addressed byte out of the returned word
   assign cart_rdata = lane_odd ? mem_rdata[7:0] : mem_rdata[15:8];

endmodule
